// ==== sim/pipe_testdata.txt ====
# Drive lines: D instr_valid instr stall (hex), one per cycle
# Expected retire records: E seq op result stall_cycles (hex), in retire order
# ALU stream, back to back
D 1 1fff 0
D 1 2150 0
D 1 3a9f 0
D 1 4ccf 0
# Stores to addresses 3, c, 7 then loads of them
D 1 60ed 0
D 1 6311 0
D 1 65fe 0
D 1 50c0 0
D 1 5300 0
D 1 51c0 0
# Stall pulses of 3, 1 and 20 cycles
D 1 1042 0
D 1 10c4 0
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 1 2242 0
D 1 454a 1
D 1 454a 0
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
D 0 0000 1
# Unknown opcodes 7 and a
D 1 7145 0
D 1 afff 0
# HLT, then words that must be ignored
D 1 f000 0
D 1 1042 0
D 1 2150 0
E 00 1 7e 0
E 01 2 f5 0
E 02 3 0a 0
E 03 4 3c 0
E 04 6 00 0
E 05 6 00 0
E 06 6 00 0
E 07 5 2d 0
E 08 5 11 0
E 09 5 3e 0
E 0a 1 03 3
E 0b 1 07 4
E 0c 2 07 f
E 0d 4 1f f
E 0e 0 00 0
E 0f 0 00 0
E 10 f 00 0

// ==== vlog.f ====
+incdir+common
common/pipe_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/writeback_stage.sv
logic/pipe_top.sv
sim/pipe_clkgen.sv
sim/pipe_assertions.sv
sim/pipe_tb.sv

// ==== Bender.yml ====
package:
  name: pipe

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/pipe_pkg.sv
      - logic/fetch_stage.sv
      - logic/decode_stage.sv
      - logic/execute_stage.sv
      - logic/memory_stage.sv
      - logic/writeback_stage.sv
      - logic/pipe_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/pipe_clkgen.sv
      - sim/pipe_assertions.sv
      - sim/pipe_tb.sv

// ==== sim/pipe_tb.sv ====
/*
 * Pipeline testbench
 * Replays the testdata drive lines and checks every retire record in order
 */
`timescale 1ns/1ps
`include "pipe_config.svh"

module pipe_tb;
    import pipe_pkg::*;

    logic                     clk, rst_n;
    logic                     instr_valid, stall;
    instr_t                   instr;
    logic                     retire_valid, halted;
    logic [`PIPE_SEQ_W-1:0]   retire_seq;
    opcode_e                  retire_op;
    data_t                    retire_result;
    logic [`PIPE_STALL_W-1:0] retire_stall_cycles;

    // Drive lines, one per cycle
    logic                     drv_valid[$];
    logic [15:0]              drv_instr[$];
    logic                     drv_stall[$];
    // Expected retire records, oldest first
    logic [`PIPE_SEQ_W-1:0]   exp_seq[$];
    logic [3:0]               exp_op[$];
    logic [7:0]               exp_result[$];
    logic [`PIPE_STALL_W-1:0] exp_stall[$];

    int seq_err, op_err, result_err, stall_err, other_err;
    int cycle_cnt, max_cycles;

    pipe_clkgen u_clkgen (.clk, .rst_n);

    pipe_top UUT (
        .clk, .rst_n, .instr_valid, .instr, .stall,
        .retire_valid, .retire_seq, .retire_op, .retire_result,
        .retire_stall_cycles, .halted
    );

    bind pipe_top pipe_assertions u_assertions (
        .clk(clk), .rst_n(rst_n), .retire_valid(retire_valid),
        .retire_seq(retire_seq), .halted(halted)
    );

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic load_testdata();
        int          fd;
        string       line;
        logic [15:0] f0, f1, f2, f3;
        fd = $fopen("sim/pipe_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the testdata file");
            other_err++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "D %h %h %h", f0, f1, f2) == 3) begin
                drv_valid.push_back(f0[0]);
                drv_instr.push_back(f1);
                drv_stall.push_back(f2[0]);
            end else if ($sscanf(line, "E %h %h %h %h", f0, f1, f2, f3) == 4) begin
                exp_seq.push_back(f0[`PIPE_SEQ_W-1:0]);
                exp_op.push_back(f1[3:0]);
                exp_result.push_back(f2[7:0]);
                exp_stall.push_back(f3[`PIPE_STALL_W-1:0]);
            end  // Comments and blank lines fall through
        end
        $fclose(fd);
    endtask

    // Compare one retire record with the oldest expected one
    task automatic check_retire();
        assert (exp_seq.size() != 0)
        else begin
            $display("Unexpected retire of seq %h after the last expected record", retire_seq);
            other_err++;
        end
        if (exp_seq.size() != 0) begin
            assert (retire_seq == exp_seq[0])
            else begin
                $display("Error retire_seq exp %h got %h", exp_seq[0], retire_seq);
                seq_err++;
            end
            assert (retire_op == exp_op[0])
            else begin
                $display("Error retire_op exp %h got %h", exp_op[0], retire_op);
                op_err++;
            end
            assert (retire_result == exp_result[0])
            else begin
                $display("Error retire_result exp %h got %h", exp_result[0], retire_result);
                result_err++;
            end
            assert (retire_stall_cycles == exp_stall[0])
            else begin
                $display("Error retire_stall_cycles exp %h got %h",
                         exp_stall[0], retire_stall_cycles);
                stall_err++;
            end
            void'(exp_seq.pop_front());
            void'(exp_op.pop_front());
            void'(exp_result.pop_front());
            void'(exp_stall.pop_front());
        end
    endtask

    function automatic int total_errors();
        return seq_err + op_err + result_err + stall_err + other_err
               + UUT.u_assertions.fail_cnt;
    endfunction

    task automatic print_counts();
        $display("Check summary: seq %0d, op %0d, result %0d, stall %0d, other %0d, assertions %0d",
                 seq_err, op_err, result_err, stall_err, other_err, UUT.u_assertions.fail_cnt);
    endtask

    //////////////////////////////////////////////////
    // Stimulus, retire monitor and timeout
    //////////////////////////////////////////////////
    initial begin
        instr_valid = 1'b0;
        instr       = '0;
        stall       = 1'b0;
        load_testdata();
        max_cycles = 20 * drv_valid.size() + 50;
        wait (rst_n === 1'b1);
        // A word refused under stall is presented again by the following line
        foreach (drv_valid[i]) begin
            @(posedge clk);
            instr_valid <= drv_valid[i];
            instr       <= drv_instr[i];
            stall       <= drv_stall[i];
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        stall       <= 1'b0;
        while (exp_seq.size() != 0)  // Drain
            @(posedge clk);
        repeat (8) @(posedge clk);   // Window for stray retires after HLT
        assert (halted === 1'b1)
        else begin
            $display("halted did not rise after HLT retired");
            other_err++;
        end
        print_counts();
        if (total_errors() == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Outputs are registered, so the pre-edge values are stable here
    always @(posedge clk) begin
        if (rst_n && retire_valid)
            check_retire();
    end

    initial begin
        wait (max_cycles != 0);
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, retirement did not finish", max_cycles);
        print_counts();
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sim/pipe_assertions.sv ====
/*
 * Pipeline assertions
 * Retire strobe, sequence order and halt behavior on the top-level ports
 */
`timescale 1ns/1ps
`include "pipe_config.svh"

module pipe_assertions (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   retire_valid,
    input logic [`PIPE_SEQ_W-1:0] retire_seq,
    input logic                   halted
);

    int unsigned            fail_cnt;     // Failed assertions, read by the testbench
    logic [`PIPE_SEQ_W-1:0] last_seq;     // Sequence number of the previous retire
    logic                   seen_retire;  // At least one retire since reset

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seen_retire <= 1'b0;
        end else if (retire_valid) begin
            seen_retire <= 1'b1;
            last_seq    <= retire_seq;
        end
    end

    //////////////////////////////////////////////////
    // Properties
    //////////////////////////////////////////////////
    retire_low_in_reset: assert property (@(posedge clk) !rst_n |=> !retire_valid)
        else begin $error("retire_valid high during reset"); fail_cnt++; end

    // Sticky until the next reset
    halted_stays_high: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else begin $error("halted fell while out of reset"); fail_cnt++; end

    seq_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid && seen_retire) |-> retire_seq == last_seq + 1'b1)  // Wraps
        else begin $error("retire_seq did not step by one"); fail_cnt++; end

    quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(halted) |=> !retire_valid)
        else begin $error("retire_valid after halted rose"); fail_cnt++; end

endmodule

// ==== sim/pipe_clkgen.sv ====
/*
 * Testbench clock and reset
 * 20 ns clock, rst_n held low for the first 4 rising edges
 */
`timescale 1ns/1ps

module pipe_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;  // Released on the edge, synchronous to the DUT
    end

endmodule

// ==== logic/pipe_top.sv ====
/*
 * Five-stage pipeline top
 * Fetch, decode, execute, memory and writeback in a chain
 */
`timescale 1ns/1ps
`include "pipe_config.svh"

module pipe_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  pipe_pkg::instr_t         instr,
    input  logic                     stall,
    output logic                     retire_valid,
    output logic [`PIPE_SEQ_W-1:0]   retire_seq,
    output pipe_pkg::opcode_e        retire_op,
    output pipe_pkg::data_t          retire_result,
    output logic [`PIPE_STALL_W-1:0] retire_stall_cycles,
    output logic                     halted
);
    import pipe_pkg::*;

    // Fetch to decode
    logic                     f_valid;
    logic [`PIPE_SEQ_W-1:0]   f_seq;
    logic [`PIPE_STALL_W-1:0] f_stall_cnt;
    instr_t                   f_instr;
    // Decode to execute
    logic                     d_valid;
    logic [`PIPE_SEQ_W-1:0]   d_seq;
    logic [`PIPE_STALL_W-1:0] d_stall_cnt;
    opcode_e                  d_op;
    operand_t                 d_a, d_b;
    // Execute to memory
    logic                     e_valid;
    logic [`PIPE_SEQ_W-1:0]   e_seq;
    logic [`PIPE_STALL_W-1:0] e_stall_cnt;
    opcode_e                  e_op;
    data_t                    e_result;
    logic [`PIPE_ADDR_W-1:0]  e_addr;
    operand_t                 e_wdata;
    // Memory to writeback
    logic                     m_valid;
    logic [`PIPE_SEQ_W-1:0]   m_seq;
    logic [`PIPE_STALL_W-1:0] m_stall_cnt;
    opcode_e                  m_op;
    data_t                    m_result;

    //////////////////////////////////////////////////
    // Stage chain
    //////////////////////////////////////////////////
    fetch_stage u_fetch (
        .clk, .rst_n, .stall, .instr_valid, .instr,
        .f_valid, .f_seq, .f_stall_cnt, .f_instr
    );

    decode_stage u_decode (
        .clk, .rst_n, .stall,
        .f_valid, .f_seq, .f_stall_cnt, .f_instr,
        .d_valid, .d_seq, .d_stall_cnt, .d_op, .d_a, .d_b
    );

    execute_stage u_execute (
        .clk, .rst_n, .stall,
        .d_valid, .d_seq, .d_stall_cnt, .d_op, .d_a, .d_b,
        .e_valid, .e_seq, .e_stall_cnt, .e_op, .e_result, .e_addr, .e_wdata
    );

    memory_stage u_memory (
        .clk, .rst_n,
        .e_valid, .e_seq, .e_stall_cnt, .e_op, .e_result, .e_addr, .e_wdata,
        .m_valid, .m_seq, .m_stall_cnt, .m_op, .m_result
    );

    writeback_stage u_writeback (
        .clk, .rst_n,
        .m_valid, .m_seq, .m_stall_cnt, .m_op, .m_result,
        .retire_valid, .retire_seq, .retire_op, .retire_result,
        .retire_stall_cycles, .halted
    );

endmodule

// ==== logic/writeback_stage.sv ====
/*
 * Writeback stage
 * Registers the retire record and latches halted after HLT retires
 */
`timescale 1ns/1ps
`include "pipe_config.svh"

module writeback_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     m_valid,
    input  logic [`PIPE_SEQ_W-1:0]   m_seq,
    input  logic [`PIPE_STALL_W-1:0] m_stall_cnt,
    input  pipe_pkg::opcode_e        m_op,
    input  pipe_pkg::data_t          m_result,
    output logic                     retire_valid,
    output logic [`PIPE_SEQ_W-1:0]   retire_seq,
    output pipe_pkg::opcode_e        retire_op,
    output pipe_pkg::data_t          retire_result,
    output logic [`PIPE_STALL_W-1:0] retire_stall_cycles,
    output logic                     halted
);
    import pipe_pkg::*;

    logic hlt_retiring;  // HLT record on the outputs this cycle

    assign hlt_retiring = retire_valid && (retire_op == HLT);

    //////////////////////////////////////////////////
    // Retire strobe and halt level
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            retire_valid <= m_valid;      // One pulse per instruction
            if (hlt_retiring)
                halted <= 1'b1;           // Sticky until reset
        end
    end

    // Record only changes with a retiring instruction
    always_ff @(posedge clk) begin
        if (m_valid) begin
            retire_seq          <= m_seq;
            retire_op           <= m_op;
            retire_result       <= m_result;
            retire_stall_cycles <= m_stall_cnt;
        end
    end

endmodule

// ==== logic/memory_stage.sv ====
/*
 * Memory stage
 * Scratch memory, written by ST and read by LD
 */
`timescale 1ns/1ps
`include "pipe_config.svh"

module memory_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     e_valid,
    input  logic [`PIPE_SEQ_W-1:0]   e_seq,
    input  logic [`PIPE_STALL_W-1:0] e_stall_cnt,
    input  pipe_pkg::opcode_e        e_op,
    input  pipe_pkg::data_t          e_result,
    input  logic [`PIPE_ADDR_W-1:0]  e_addr,
    input  pipe_pkg::operand_t       e_wdata,
    output logic                     m_valid,
    output logic [`PIPE_SEQ_W-1:0]   m_seq,
    output logic [`PIPE_STALL_W-1:0] m_stall_cnt,
    output pipe_pkg::opcode_e        m_op,
    output pipe_pkg::data_t          m_result
);
    import pipe_pkg::*;

    data_t mem [`PIPE_MEM_DEPTH];  // Scratch storage, contents undefined after reset
    data_t rd_data;

    assign rd_data = mem[e_addr];  // Asynchronous read, old value on same-cycle write

    //////////////////////////////////////////////////
    // Store
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (e_valid && e_op == ST)
            mem[e_addr] <= data_t'(e_wdata);  // Operand b, zero-extended
    end

    always_ff @(posedge clk) begin
        if (!rst_n) m_valid <= 1'b0;
        else        m_valid <= e_valid;
    end

    // Loads swap in the memory word
    always_ff @(posedge clk) begin
        m_seq       <= e_seq;
        m_stall_cnt <= e_stall_cnt;
        m_op        <= e_op;
        m_result    <= (e_op == LD) ? rd_data : e_result;
    end

endmodule

// ==== logic/execute_stage.sv ====
/*
 * Execute stage
 * ALU on the zero-extended operands and memory address generation
 */
`timescale 1ns/1ps
`include "pipe_config.svh"

module execute_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stall,
    input  logic                     d_valid,
    input  logic [`PIPE_SEQ_W-1:0]   d_seq,
    input  logic [`PIPE_STALL_W-1:0] d_stall_cnt,
    input  pipe_pkg::opcode_e        d_op,
    input  pipe_pkg::operand_t       d_a,
    input  pipe_pkg::operand_t       d_b,
    output logic                     e_valid,
    output logic [`PIPE_SEQ_W-1:0]   e_seq,
    output logic [`PIPE_STALL_W-1:0] e_stall_cnt,
    output pipe_pkg::opcode_e        e_op,
    output pipe_pkg::data_t          e_result,
    output logic [`PIPE_ADDR_W-1:0]  e_addr,
    output pipe_pkg::operand_t       e_wdata
);
    import pipe_pkg::*;

    data_t a_ext, b_ext, alu;

    assign a_ext = data_t'(d_a);
    assign b_ext = data_t'(d_b);

    // Results wrap mod 256, LD is filled in by the memory stage
    always_comb begin
        case (d_op)
            ADD:     alu = a_ext + b_ext;
            SUB:     alu = a_ext - b_ext;
            AND:     alu = a_ext & b_ext;
            XOR:     alu = a_ext ^ b_ext;
            default: alu = '0;            // NOP, LD, ST, HLT
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) e_valid <= 1'b0;
        else        e_valid <= d_valid && !stall;  // Bubble while decode is frozen
    end

    always_ff @(posedge clk) begin
        e_seq       <= d_seq;
        e_stall_cnt <= d_stall_cnt;
        e_op        <= d_op;
        e_result    <= alu;
        e_addr      <= d_a[`PIPE_ADDR_W-1:0];  // Low bits of operand a
        e_wdata     <= d_b;                    // Store data
    end

endmodule

// ==== logic/decode_stage.sv ====
/*
 * Decode stage
 * Splits the word into opcode and operands, freezes under stall
 */
`timescale 1ns/1ps
`include "pipe_config.svh"

module decode_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stall,
    input  logic                     f_valid,
    input  logic [`PIPE_SEQ_W-1:0]   f_seq,
    input  logic [`PIPE_STALL_W-1:0] f_stall_cnt,
    input  pipe_pkg::instr_t         f_instr,
    output logic                     d_valid,
    output logic [`PIPE_SEQ_W-1:0]   d_seq,
    output logic [`PIPE_STALL_W-1:0] d_stall_cnt,
    output pipe_pkg::opcode_e        d_op,
    output pipe_pkg::operand_t       d_a,
    output pipe_pkg::operand_t       d_b
);
    import pipe_pkg::*;

    opcode_e op_dec;  // Opcode field mapped onto the enum

    // Known codes pass through, the rest become NOP
    always_comb begin
        case (opcode_e'(f_instr.op))
            ADD, SUB, AND, XOR, LD, ST, HLT: op_dec = opcode_e'(f_instr.op);
            default:                         op_dec = NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid     <= 1'b0;
            d_stall_cnt <= '0;
        end else if (stall) begin
            if (d_valid && d_stall_cnt != '1)  // Saturating
                d_stall_cnt <= d_stall_cnt + 1'b1;
        end else begin
            d_valid     <= f_valid;
            d_stall_cnt <= f_stall_cnt;        // Carries cycles frozen in fetch
        end
    end

    // Fields, held while stalled
    always_ff @(posedge clk) begin
        if (!stall) begin
            d_seq <= f_seq;
            d_op  <= op_dec;
            d_a   <= f_instr.a;
            d_b   <= f_instr.b;
        end
    end

endmodule

// ==== logic/fetch_stage.sv ====
/*
 * Fetch stage
 * Takes instruction words, stamps sequence numbers, stops after HLT
 */
`timescale 1ns/1ps
`include "pipe_config.svh"

module fetch_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stall,
    input  logic                     instr_valid,
    input  pipe_pkg::instr_t         instr,
    output logic                     f_valid,
    output logic [`PIPE_SEQ_W-1:0]   f_seq,
    output logic [`PIPE_STALL_W-1:0] f_stall_cnt,
    output pipe_pkg::instr_t         f_instr
);
    import pipe_pkg::*;

    logic [`PIPE_SEQ_W-1:0] seq_cnt;  // Number for the next accepted word
    logic                   stopped;  // HLT already taken
    logic                   accept;

    assign accept = instr_valid && !stall && !stopped;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            f_valid     <= 1'b0;
            f_stall_cnt <= '0;
            seq_cnt     <= '0;
            stopped     <= 1'b0;
        end else if (stall) begin
            // Hold the word, count frozen cycles up to the limit
            if (f_valid && f_stall_cnt != '1)
                f_stall_cnt <= f_stall_cnt + 1'b1;
        end else begin
            f_valid     <= accept;
            f_stall_cnt <= '0;                  // Fresh word starts unstalled
            if (accept) begin
                seq_cnt <= seq_cnt + 1'b1;      // Wraps
                stopped <= (instr.op == HLT);   // Nothing after HLT
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (accept) begin
            f_instr <= instr;
            f_seq   <= seq_cnt;
        end
    end

endmodule

// ==== common/pipe_pkg.sv ====
/*
 * Pipeline package
 * Opcode encoding and the field types of the 16-bit instruction word
 */
package pipe_pkg;

    //////////////////////////////////////////////////
    // Field widths
    //////////////////////////////////////////////////
    localparam int OP_W      = 4;  // Opcode field
    localparam int OPERAND_W = 6;  // Each operand field
    localparam int DATA_W    = 8;  // Result and memory word

    typedef logic [OP_W-1:0]      op_field_t;
    typedef logic [OPERAND_W-1:0] operand_t;
    typedef logic [DATA_W-1:0]    data_t;

    // Raw instruction word, opcode on top
    typedef struct packed {
        op_field_t op;  // [15:12]
        operand_t  a;   // [11:6]
        operand_t  b;   // [5:0]
    } instr_t;

    //////////////////////////////////////////////////
    // Operations
    //////////////////////////////////////////////////
    // Codes not listed here decode to NOP
    typedef enum logic [OP_W-1:0] {
        NOP = 4'd0,
        ADD = 4'd1,
        SUB = 4'd2,
        AND = 4'd3,
        XOR = 4'd4,
        LD  = 4'd5,   // Load from scratch memory
        ST  = 4'd6,   // Store operand b
        HLT = 4'd15   // Stops fetch
    } opcode_e;

endpackage

// ==== common/pipe_config.svh ====
/*
 * Pipeline configuration
 * Sizes shared by the stages
 */
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// Sequence number width, wraps around
`define PIPE_SEQ_W 8

// Stall cycle counter, saturates at all ones
`define PIPE_STALL_W 4

// Scratch memory entries and the derived address width
`define PIPE_MEM_DEPTH 16
`define PIPE_ADDR_W $clog2(`PIPE_MEM_DEPTH)

`endif
